// File: logic/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~
// data and port counts
`define MEM_WIDTH      16
`define MEM_NUMRDPT    2
`define MEM_NUMWRPT    2

// ~~~~~~~~~~~~~~~~~~~~
// logical address space
`define MEM_NUMADDR    96
`define MEM_BITADDR    7

// ~~~~~~~~~~~~~~~~~~~~
// bank geometry, bank count is not a power of two
`define MEM_NUMVBNK    6
`define MEM_BITVBNK    3
`define MEM_NUMVROW    16
`define MEM_BITVROW    4
`define MEM_BITPADR    (`MEM_BITVBNK + `MEM_BITVROW)

`define MEM_SRAM_DELAY 2      // cycles from bank read to bank dout

`endif

// File: logic/mem_pkg.sv
package mem_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // command to one bank in one cycle
  typedef enum logic [1:0] {
    BANK_IDLE  = 2'd0,
    BANK_READ  = 2'd1,
    BANK_WRITE = 2'd2
  } bank_op_e;

endpackage

// File: logic/np2_addr.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module np2_addr (
  input  logic [`MEM_BITADDR-1:0] vaddr,
  output logic [`MEM_BITVBNK-1:0] vbadr,
  output logic [`MEM_BITVROW-1:0] vradr
);

  logic [`MEM_BITADDR-1:0] bank_full;
  logic [`MEM_BITADDR-1:0] row_full;

  // ~~~~~~~~~~~~~~~~~~~~
  // consecutive addresses rotate across the banks
  assign bank_full = vaddr % `MEM_BITADDR'(`MEM_NUMVBNK);
  assign row_full  = vaddr / `MEM_BITADDR'(`MEM_NUMVBNK);  // constant divisor, stays combinational

  assign vbadr = bank_full[`MEM_BITVBNK-1:0];
  assign vradr = row_full[`MEM_BITVROW-1:0];  // only in-range addresses reach a bank

endmodule

// File: logic/bank_router.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module bank_router (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [`MEM_NUMWRPT-1:0]               write,
  input  logic [`MEM_NUMWRPT*`MEM_BITADDR-1:0]  wr_adr,
  input  logic [`MEM_NUMWRPT*`MEM_WIDTH-1:0]    din,
  input  logic [`MEM_NUMRDPT-1:0]               read,
  input  logic [`MEM_NUMRDPT*`MEM_BITADDR-1:0]  rd_adr,
  output logic [`MEM_NUMWRPT-1:0]               wr_rej,
  output logic [`MEM_NUMRDPT-1:0]               rd_rej,
  output mem_pkg::bank_op_e [`MEM_NUMVBNK-1:0]  bank_op,
  output logic [`MEM_NUMVBNK*`MEM_BITVROW-1:0]  bank_row,
  output logic [`MEM_NUMVBNK*`MEM_WIDTH-1:0]    bank_din,
  output logic [`MEM_NUMRDPT-1:0]               rd_gnt,
  output logic [`MEM_NUMRDPT*`MEM_BITVBNK-1:0]  rd_gnt_bank,
  output logic [`MEM_NUMRDPT*`MEM_BITVROW-1:0]  rd_gnt_row
);

  import mem_pkg::*;

  logic [`MEM_BITVBNK-1:0] wr_bank [`MEM_NUMWRPT];
  logic [`MEM_BITVROW-1:0] wr_row  [`MEM_NUMWRPT];
  logic [`MEM_NUMWRPT-1:0] wr_oor;
  logic [`MEM_NUMWRPT-1:0] wr_gnt;
  logic [`MEM_BITVBNK-1:0] rd_bank [`MEM_NUMRDPT];
  logic [`MEM_BITVROW-1:0] rd_row  [`MEM_NUMRDPT];
  logic [`MEM_NUMRDPT-1:0] rd_oor;
  logic [`MEM_NUMVBNK-1:0] taken;

  // ~~~~~~~~~~~~~~~~~~~~
  // address decode per port
  for (genvar w = 0; w < `MEM_NUMWRPT; w++) begin : g_wr_dec
    np2_addr u_wr_addr (
      .vaddr (wr_adr[w*`MEM_BITADDR +: `MEM_BITADDR]),
      .vbadr (wr_bank[w]),
      .vradr (wr_row[w])
    );
    assign wr_oor[w] = wr_adr[w*`MEM_BITADDR +: `MEM_BITADDR] >= `MEM_BITADDR'(`MEM_NUMADDR);
  end

  for (genvar r = 0; r < `MEM_NUMRDPT; r++) begin : g_rd_dec
    np2_addr u_rd_addr (
      .vaddr (rd_adr[r*`MEM_BITADDR +: `MEM_BITADDR]),
      .vbadr (rd_bank[r]),
      .vradr (rd_row[r])
    );
    assign rd_oor[r] = rd_adr[r*`MEM_BITADDR +: `MEM_BITADDR] >= `MEM_BITADDR'(`MEM_NUMADDR);
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // fixed priority, writes ahead of reads and lower port numbers first
  always_comb begin
    taken       = '0;
    wr_gnt      = '0;
    wr_rej      = '0;
    rd_gnt      = '0;
    rd_rej      = '0;
    bank_row    = '0;
    bank_din    = '0;
    rd_gnt_bank = '0;
    rd_gnt_row  = '0;
    for (int b = 0; b < `MEM_NUMVBNK; b++) begin
      bank_op[b] = BANK_IDLE;
    end
    if (!rst) begin
      for (int w = 0; w < `MEM_NUMWRPT; w++) begin
        if (write[w]) begin
          if (wr_oor[w] || taken[wr_bank[w]]) begin
            wr_rej[w] = 1'b1;  // out-of-range ports never claim a bank
          end else begin
            wr_gnt[w]           = 1'b1;
            taken[wr_bank[w]]   = 1'b1;
            bank_op[wr_bank[w]] = BANK_WRITE;
            bank_row[wr_bank[w]*`MEM_BITVROW +: `MEM_BITVROW] = wr_row[w];
            bank_din[wr_bank[w]*`MEM_WIDTH +: `MEM_WIDTH]     = din[w*`MEM_WIDTH +: `MEM_WIDTH];
          end
        end
      end
      for (int r = 0; r < `MEM_NUMRDPT; r++) begin
        if (read[r]) begin
          if (rd_oor[r] || taken[rd_bank[r]]) begin
            rd_rej[r] = 1'b1;  // includes a same-bank write, no forwarding
          end else begin
            rd_gnt[r]           = 1'b1;
            taken[rd_bank[r]]   = 1'b1;
            bank_op[rd_bank[r]] = BANK_READ;
            bank_row[rd_bank[r]*`MEM_BITVROW +: `MEM_BITVROW]      = rd_row[r];
            rd_gnt_bank[r*`MEM_BITVBNK +: `MEM_BITVBNK]            = rd_bank[r];
            rd_gnt_row[r*`MEM_BITVROW +: `MEM_BITVROW]             = rd_row[r];
          end
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // checks across all ports
  for (genvar b = 0; b < `MEM_NUMVBNK; b++) begin : g_bank_chk
    logic [`MEM_NUMWRPT+`MEM_NUMRDPT-1:0] owners;
    for (genvar w = 0; w < `MEM_NUMWRPT; w++) begin : g_wr_own
      assign owners[w] = wr_gnt[w] && (wr_bank[w] == `MEM_BITVBNK'(b));
    end
    for (genvar r = 0; r < `MEM_NUMRDPT; r++) begin : g_rd_own
      assign owners[`MEM_NUMWRPT+r] = rd_gnt[r] && (rd_bank[r] == `MEM_BITVBNK'(b));
    end
    a_one_owner: assert property (@(posedge clk) disable iff (rst) $onehot0(owners));
  end

  a_wr_gnt_range: assert property (@(posedge clk) disable iff (rst) (wr_gnt & wr_oor) == '0);
  a_rd_gnt_range: assert property (@(posedge clk) disable iff (rst) (rd_gnt & rd_oor) == '0);

endmodule

// File: logic/sram_1rw.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module sram_1rw (
  input  logic                    clk,
  input  mem_pkg::bank_op_e       op,
  input  logic [`MEM_BITVROW-1:0] row,
  input  logic [`MEM_WIDTH-1:0]   din,
  output logic [`MEM_WIDTH-1:0]   dout
);

  import mem_pkg::*;

  logic [`MEM_WIDTH-1:0] mem     [`MEM_NUMVROW];
  logic [`MEM_WIDTH-1:0] rd_pipe [`MEM_SRAM_DELAY];

  // ~~~~~~~~~~~~~~~~~~~~
  // storage array
  always_ff @(posedge clk) begin
    if (op == BANK_WRITE) begin
      mem[row] <= din;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // read latency pipeline
  always_ff @(posedge clk) begin
    if (op == BANK_READ) begin
      rd_pipe[0] <= mem[row];  // stage 0 loads at the edge that samples the read
    end
    for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign dout = rd_pipe[`MEM_SRAM_DELAY-1];

  a_row_range: assert property (@(posedge clk)
    (op != BANK_IDLE) |-> (int'(row) < `MEM_NUMVROW));

endmodule

// File: logic/read_return.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module read_return (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [`MEM_NUMRDPT-1:0]               rd_gnt,
  input  logic [`MEM_NUMRDPT*`MEM_BITVBNK-1:0]  rd_gnt_bank,
  input  logic [`MEM_NUMRDPT*`MEM_BITVROW-1:0]  rd_gnt_row,
  input  logic [`MEM_NUMVBNK*`MEM_WIDTH-1:0]    bank_dout,
  output logic [`MEM_NUMRDPT-1:0]               rd_vld,
  output logic [`MEM_NUMRDPT*`MEM_WIDTH-1:0]    rd_dout,
  output logic [`MEM_NUMRDPT*`MEM_BITPADR-1:0]  rd_padr
);

  logic [`MEM_SRAM_DELAY-1:0] vld_pipe  [`MEM_NUMRDPT];
  logic [`MEM_BITVBNK-1:0]    bank_pipe [`MEM_NUMRDPT][`MEM_SRAM_DELAY];
  logic [`MEM_BITVROW-1:0]    row_pipe  [`MEM_NUMRDPT][`MEM_SRAM_DELAY];

  // ~~~~~~~~~~~~~~~~~~~~
  // grant tracking, same depth as the bank read pipeline
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < `MEM_NUMRDPT; p++) begin
        vld_pipe[p] <= '0;
      end
    end else begin
      for (int p = 0; p < `MEM_NUMRDPT; p++) begin
        vld_pipe[p][0] <= rd_gnt[p];
        for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
          vld_pipe[p][i] <= vld_pipe[p][i-1];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < `MEM_NUMRDPT; p++) begin
      bank_pipe[p][0] <= rd_gnt_bank[p*`MEM_BITVBNK +: `MEM_BITVBNK];
      row_pipe[p][0]  <= rd_gnt_row[p*`MEM_BITVROW +: `MEM_BITVROW];
      for (int i = 1; i < `MEM_SRAM_DELAY; i++) begin
        bank_pipe[p][i] <= bank_pipe[p][i-1];
        row_pipe[p][i]  <= row_pipe[p][i-1];
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // output steering per read port
  for (genvar p = 0; p < `MEM_NUMRDPT; p++) begin : g_port
    logic [`MEM_BITVBNK-1:0] last_bank;
    logic [`MEM_BITVROW-1:0] last_row;

    assign last_bank = bank_pipe[p][`MEM_SRAM_DELAY-1];
    assign last_row  = row_pipe[p][`MEM_SRAM_DELAY-1];

    assign rd_vld[p]                                = vld_pipe[p][`MEM_SRAM_DELAY-1];
    assign rd_dout[p*`MEM_WIDTH +: `MEM_WIDTH]      = bank_dout[last_bank*`MEM_WIDTH +: `MEM_WIDTH];
    assign rd_padr[p*`MEM_BITPADR +: `MEM_BITPADR]  = {last_bank, last_row};  // bank in the upper field

    a_padr_bank: assert property (@(posedge clk) disable iff (rst)
      rd_vld[p] |-> (last_bank < `MEM_BITVBNK'(`MEM_NUMVBNK)));
  end

endmodule

// File: logic/mrnw_mem_top.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mrnw_mem_top (
  input  logic                                  clk,
  input  logic                                  rst,
  input  logic [`MEM_NUMWRPT-1:0]               write,
  input  logic [`MEM_NUMWRPT*`MEM_BITADDR-1:0]  wr_adr,
  input  logic [`MEM_NUMWRPT*`MEM_WIDTH-1:0]    din,
  input  logic [`MEM_NUMRDPT-1:0]               read,
  input  logic [`MEM_NUMRDPT*`MEM_BITADDR-1:0]  rd_adr,
  output logic [`MEM_NUMWRPT-1:0]               wr_rej,
  output logic [`MEM_NUMRDPT-1:0]               rd_rej,
  output logic [`MEM_NUMRDPT-1:0]               rd_vld,
  output logic [`MEM_NUMRDPT*`MEM_WIDTH-1:0]    rd_dout,
  output logic [`MEM_NUMRDPT*`MEM_BITPADR-1:0]  rd_padr
);

  import mem_pkg::*;

  bank_op_e [`MEM_NUMVBNK-1:0]         bank_op;
  logic [`MEM_NUMVBNK*`MEM_BITVROW-1:0] bank_row;
  logic [`MEM_NUMVBNK*`MEM_WIDTH-1:0]   bank_din;
  logic [`MEM_NUMVBNK*`MEM_WIDTH-1:0]   bank_dout;
  logic [`MEM_NUMRDPT-1:0]              rd_gnt;
  logic [`MEM_NUMRDPT*`MEM_BITVBNK-1:0] rd_gnt_bank;
  logic [`MEM_NUMRDPT*`MEM_BITVROW-1:0] rd_gnt_row;

  bank_router u_router (
    .clk         (clk),
    .rst         (rst),
    .write       (write),
    .wr_adr      (wr_adr),
    .din         (din),
    .read        (read),
    .rd_adr      (rd_adr),
    .wr_rej      (wr_rej),
    .rd_rej      (rd_rej),
    .bank_op     (bank_op),
    .bank_row    (bank_row),
    .bank_din    (bank_din),
    .rd_gnt      (rd_gnt),
    .rd_gnt_bank (rd_gnt_bank),
    .rd_gnt_row  (rd_gnt_row)
  );

  // ~~~~~~~~~~~~~~~~~~~~
  // one single-port macro per bank
  for (genvar b = 0; b < `MEM_NUMVBNK; b++) begin : g_bank
    sram_1rw u_sram (
      .clk  (clk),
      .op   (bank_op[b]),
      .row  (bank_row[b*`MEM_BITVROW +: `MEM_BITVROW]),
      .din  (bank_din[b*`MEM_WIDTH +: `MEM_WIDTH]),
      .dout (bank_dout[b*`MEM_WIDTH +: `MEM_WIDTH])
    );
  end

  read_return u_return (
    .clk         (clk),
    .rst         (rst),
    .rd_gnt      (rd_gnt),
    .rd_gnt_bank (rd_gnt_bank),
    .rd_gnt_row  (rd_gnt_row),
    .bank_dout   (bank_dout),
    .rd_vld      (rd_vld),
    .rd_dout     (rd_dout),
    .rd_padr     (rd_padr)
  );

endmodule

// File: test/mrnw_mem_tb.sv
`timescale 1ns/1ps
`include "mem_macros.svh"

module mrnw_mem_tb;

  localparam int NW          = `MEM_NUMWRPT;
  localparam int NR          = `MEM_NUMRDPT;
  localparam int DRAIN       = `MEM_SRAM_DELAY + 2;
  localparam int TEST_CYCLES = 16 + `MEM_NUMADDR + 40 + 300 + 48 + 200 + 5 * DRAIN;
  localparam int WATCHDOG_NS = TEST_CYCLES * 10 + 2000;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  logic                           clk = 1'b0;
  logic                           rst;
  logic [NW-1:0]                  write;
  logic [NW*`MEM_BITADDR-1:0]     wr_adr;
  logic [NW*`MEM_WIDTH-1:0]       din;
  logic [NR-1:0]                  read;
  logic [NR*`MEM_BITADDR-1:0]     rd_adr;
  logic [NW-1:0]                  wr_rej;
  logic [NR-1:0]                  rd_rej;
  logic [NR-1:0]                  rd_vld;
  logic [NR*`MEM_WIDTH-1:0]       rd_dout;
  logic [NR*`MEM_BITPADR-1:0]     rd_padr;

  // requests for the next cycle stay idle unless a test sets them
  logic [NW-1:0]                  nx_write;
  logic [`MEM_BITADDR-1:0]        nx_wadr [NW];
  logic [`MEM_WIDTH-1:0]          nx_din  [NW];
  logic [NR-1:0]                  nx_read;
  logic [`MEM_BITADDR-1:0]        nx_radr [NR];

  logic [`MEM_WIDTH-1:0]          model_mem   [`MEM_NUMADDR];
  logic                           model_known [`MEM_NUMADDR];
  int                             q_cyc   [$];
  int                             q_port  [$];
  logic [`MEM_WIDTH-1:0]          q_data  [$];
  logic [`MEM_BITPADR-1:0]        q_padr  [$];
  logic                           q_known [$];

  logic [`MEM_BITADDR-1:0]        lost_adr [24];
  logic [`MEM_BITADDR-1:0]        a;
  logic [31:0]                    lfsr = 32'h7e4;
  int                             cyc;
  int                             errors;
  int                             checks;
  int                             tests;
  int                             err_base;

  mrnw_mem_top UUT (
    .clk     (clk),
    .rst     (rst),
    .write   (write),
    .wr_adr  (wr_adr),
    .din     (din),
    .read    (read),
    .rd_adr  (rd_adr),
    .wr_rej  (wr_rej),
    .rd_rej  (rd_rej),
    .rd_vld  (rd_vld),
    .rd_dout (rd_dout),
    .rd_padr (rd_padr)
  );

  always #5 clk = ~clk;

  // ~~~~~~~~~~~~~~~~~~~~
  // random source and reporting
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);  // one Galois step per bit
    end
    return val;
  endfunction

  task automatic report_mismatch(input string sig, input int idx,
                                 input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("FAILED t=%0t %s[%0d] expected %0h got %0h", $time, sig, idx, exp, act);
  endtask

  task automatic clear_requests;
    nx_write = '0;
    nx_read  = '0;
    for (int i = 0; i < NW; i++) begin
      nx_wadr[i] = '0;
      nx_din[i]  = '0;
    end
    for (int i = 0; i < NR; i++) begin
      nx_radr[i] = '0;
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // reference model
  task automatic check_requests;
    logic [`MEM_NUMVBNK-1:0] busy;
    logic                    exp_rej;
    int                      b;
    busy = '0;
    for (int w = 0; w < NW; w++) begin
      b       = nx_wadr[w] % `MEM_NUMVBNK;
      exp_rej = nx_write[w] && ((nx_wadr[w] >= `MEM_NUMADDR) || busy[b]);
      checks++;
      if (wr_rej[w] !== exp_rej) report_mismatch("wr_rej", w, exp_rej, wr_rej[w]);
      if (nx_write[w] && !exp_rej) begin
        busy[b]                 = 1'b1;
        model_mem[nx_wadr[w]]   = nx_din[w];
        model_known[nx_wadr[w]] = 1'b1;
      end
    end
    for (int r = 0; r < NR; r++) begin
      b       = nx_radr[r] % `MEM_NUMVBNK;
      exp_rej = nx_read[r] && ((nx_radr[r] >= `MEM_NUMADDR) || busy[b]);
      checks++;
      if (rd_rej[r] !== exp_rej) report_mismatch("rd_rej", r, exp_rej, rd_rej[r]);
      if (nx_read[r] && !exp_rej) begin
        busy[b] = 1'b1;
        q_cyc.push_back(cyc + `MEM_SRAM_DELAY);
        q_port.push_back(r);
        q_data.push_back(model_mem[nx_radr[r]]);
        q_padr.push_back({`MEM_BITVBNK'(b), `MEM_BITVROW'(nx_radr[r] / `MEM_NUMVBNK)});
        q_known.push_back(model_known[nx_radr[r]]);
      end
    end
  endtask

  task automatic check_returns;
    logic [NR-1:0]           exp_v;
    logic [`MEM_WIDTH-1:0]   exp_d [NR];
    logic [`MEM_BITPADR-1:0] exp_a [NR];
    logic                    exp_k [NR];
    int                      p;
    exp_v = '0;
    while (q_cyc.size() > 0 && q_cyc[0] == cyc) begin
      p        = q_port.pop_front();
      exp_v[p] = 1'b1;
      exp_d[p] = q_data.pop_front();
      exp_a[p] = q_padr.pop_front();
      exp_k[p] = q_known.pop_front();
      void'(q_cyc.pop_front());
    end
    for (int i = 0; i < NR; i++) begin
      checks++;
      if (exp_v[i] && rd_vld[i] !== 1'b1) begin
        errors++;
        $display("read port %0d: result due at t=%0t never showed rd_vld", i, $time);
      end else if (!exp_v[i] && rd_vld[i] !== 1'b0) begin
        errors++;
        $display("read port %0d: rd_vld at t=%0t with no read pending", i, $time);
      end else if (exp_v[i]) begin
        if (rd_padr[i*`MEM_BITPADR +: `MEM_BITPADR] !== exp_a[i])
          report_mismatch("rd_padr", i, exp_a[i], rd_padr[i*`MEM_BITPADR +: `MEM_BITPADR]);
        if (exp_k[i] && rd_dout[i*`MEM_WIDTH +: `MEM_WIDTH] !== exp_d[i])
          report_mismatch("rd_dout", i, exp_d[i], rd_dout[i*`MEM_WIDTH +: `MEM_WIDTH]);
      end
    end
  endtask

  // ~~~~~~~~~~~~~~~~~~~~
  // results are checked before the next requests go out
  task automatic run_cycle;
    @(negedge clk);
    cyc++;
    check_returns();
    write = nx_write;
    read  = nx_read;
    for (int w = 0; w < NW; w++) begin
      wr_adr[w*`MEM_BITADDR +: `MEM_BITADDR] = nx_wadr[w];
      din[w*`MEM_WIDTH +: `MEM_WIDTH]        = nx_din[w];
    end
    for (int r = 0; r < NR; r++) begin
      rd_adr[r*`MEM_BITADDR +: `MEM_BITADDR] = nx_radr[r];
    end
    #1;
    check_requests();  // rejects settle within the request cycle
    clear_requests();
  endtask

  task automatic finish_test(input string name);
    repeat (DRAIN) run_cycle();
    tests++;
    $display("test %0d %s done with %0d errors", tests, name, errors - err_base);
    err_base = errors;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("run stopped by watchdog after %0d ns", WATCHDOG_NS);
    $display("Checks failed");
    $finish;
  end

  initial begin
    rst    = 1'b1;
    write  = '0;
    wr_adr = '0;
    din    = '0;
    read   = '0;
    rd_adr = '0;
    cyc    = 0;
    errors = 0;
    checks = 0;
    tests  = 0;
    err_base = 0;
    clear_requests();
    for (int i = 0; i < `MEM_NUMADDR; i++) begin
      model_known[i] = 1'b0;
    end
    repeat (16) @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < `MEM_NUMADDR / 2; i++) begin
      for (int w = 0; w < NW; w++) begin
        nx_write[w] = 1'b1;
        nx_wadr[w]  = `MEM_BITADDR'(2 * i + w);  // neighbours never share a bank
        nx_din[w]   = rand_bits(16);
      end
      run_cycle();
    end
    for (int i = 0; i < `MEM_NUMADDR / 2; i++) begin
      for (int r = 0; r < NR; r++) begin
        nx_read[r] = 1'b1;
        nx_radr[r] = `MEM_BITADDR'(2 * i + r);
      end
      run_cycle();
    end
    finish_test("fill and read back");

    for (int i = 0; i < 40; i++) begin
      a          = `MEM_BITADDR'(rand_bits(7) % `MEM_NUMADDR);
      nx_read    = '1;
      nx_radr[0] = a;
      nx_radr[1] = `MEM_BITADDR'((a + 1) % `MEM_NUMADDR);
      run_cycle();
    end
    finish_test("back-to-back reads");

    for (int i = 0; i < 300; i++) begin
      for (int w = 0; w < NW; w++) begin
        nx_write[w] = (rand_bits(2) != 0);
        nx_wadr[w]  = `MEM_BITADDR'(rand_bits(7) % `MEM_NUMADDR);
        nx_din[w]   = rand_bits(16);
      end
      for (int r = 0; r < NR; r++) begin
        nx_read[r] = (rand_bits(2) != 0);
        nx_radr[r] = `MEM_BITADDR'(rand_bits(7) % `MEM_NUMADDR);
      end
      run_cycle();
    end
    finish_test("random conflicting traffic");

    for (int i = 0; i < 24; i++) begin
      a           = `MEM_BITADDR'(rand_bits(7) % `MEM_NUMADDR);
      lost_adr[i] = `MEM_BITADDR'((a + `MEM_NUMVBNK) % `MEM_NUMADDR);  // same bank as a
      nx_write    = '1;
      nx_wadr[0]  = a;
      nx_wadr[1]  = lost_adr[i];
      nx_din[0]   = rand_bits(16);
      nx_din[1]   = rand_bits(16);
      run_cycle();
    end
    for (int i = 0; i < 24; i++) begin
      nx_read[0] = 1'b1;
      nx_radr[0] = lost_adr[i];
      run_cycle();
    end
    finish_test("rejected writes");

    for (int i = 0; i < 200; i++) begin
      for (int w = 0; w < NW; w++) begin
        nx_write[w] = rand_bits(1);
        nx_wadr[w]  = rand_bits(1) ? `MEM_BITADDR'(`MEM_NUMADDR + rand_bits(5))
                                   : `MEM_BITADDR'(rand_bits(7) % `MEM_NUMADDR);
        nx_din[w]   = rand_bits(16);
      end
      for (int r = 0; r < NR; r++) begin
        nx_read[r] = rand_bits(1);
        nx_radr[r] = rand_bits(1) ? `MEM_BITADDR'(`MEM_NUMADDR + rand_bits(5))
                                  : `MEM_BITADDR'(rand_bits(7) % `MEM_NUMADDR);
      end
      run_cycle();
    end
    finish_test("out-of-range addresses");

    $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+logic
logic/mem_pkg.sv
logic/np2_addr.sv
logic/bank_router.sv
logic/sram_1rw.sv
logic/read_return.sv
logic/mrnw_mem_top.sv
test/mrnw_mem_tb.sv
